/* Makefile */
# Verilator build and run of the dual-bank memory model testbench

TOP := emif_dual_bank_model_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

# Builds the simulation binary with assertions and timing support
compile:
	verilator --binary --timing --assert -j 0 \
		--top-module $(TOP) \
		-f emif_dual_bank_model.f \
		--Mdir obj_dir -o $(TOP)

# Runs the binary and decides pass or fail from the log
run: compile
	./obj_dir/$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation did not complete"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

/* emif_bank.sv */
/*
 Burst controller for one memory bank with Avalon-style read and write strobes.
 burstcount must be at least 1 and no new read may start while waitrequest is high.
 Read has priority when both strobes are high in idle.
*/

`timescale 1ns/10ps

module emif_bank (
  input  logic                                  DDR4_USERCLK,
  input  logic                                  reset,
  // Host command side
  input  logic                                  read,
  input  logic                                  write,
  input  logic [emif_model_pkg::addr_w-1:0]     address,
  input  logic [emif_model_pkg::burst_w-1:0]    burstcount,
  input  logic [emif_model_pkg::data_w-1:0]     writedata,
  input  logic [emif_model_pkg::data_bytes-1:0] byteenable,
  // Model response side
  output logic                                  waitrequest,
  output logic                                  readdatavalid,
  output logic [emif_model_pkg::data_w-1:0]     readdata
);

  // ============================================================
  // Controller state
  // ============================================================

  // Current burst type, idle between bursts
  emif_model_pkg::bank_state_t state;

  // Beats still to transfer in the running burst
  logic [emif_model_pkg::burst_w-1:0] beats_left;

  // Storage address of the next beat
  // Only the decoded bits are kept, so the burst wraps inside the bank
  logic [emif_model_pkg::mem_addr_w-1:0] burst_addr;

  // Byte enables taken with the first word of a write burst
  logic [emif_model_pkg::data_bytes-1:0] burst_byteenable;

  // Command acceptance in idle
  logic accept_read;
  logic accept_write;

  // Storage connections
  logic                                  store_wr_en;
  logic [emif_model_pkg::mem_addr_w-1:0] store_wr_addr;
  logic [emif_model_pkg::data_bytes-1:0] store_wr_byteenable;
  logic [emif_model_pkg::data_w-1:0]     store_rd_data;

  // ============================================================
  // Command decode
  // ============================================================

  // A read in idle always wins over a write in the same cycle
  assign accept_read  = (state == emif_model_pkg::st_idle) && read;
  assign accept_write = (state == emif_model_pkg::st_idle) && !read && write;

  // The host is held off only for the length of a read burst
  assign waitrequest = (state == emif_model_pkg::st_read_burst);

  // The first write beat goes straight to storage at the accepting edge
  // Later beats use the running address and the captured byte enables
  always_comb begin
    store_wr_en         = accept_write;
    store_wr_addr       = address[emif_model_pkg::mem_addr_w-1:0];
    store_wr_byteenable = byteenable;
    if (state == emif_model_pkg::st_write_burst) begin
      store_wr_en         = write;
      store_wr_addr       = burst_addr;
      store_wr_byteenable = burst_byteenable;
    end
  end

  // ============================================================
  // Burst FSM
  // ============================================================

  always_ff @(posedge DDR4_USERCLK) begin
    if (reset) begin
      state         <= emif_model_pkg::st_idle;
      beats_left    <= '0;
      burst_addr    <= '0;
      readdatavalid <= 1'b0;
      readdata      <= '0;
    end else begin
      // Valid is a one-cycle pulse per returned word
      readdatavalid <= 1'b0;
      case (state)
        emif_model_pkg::st_idle: begin
          if (accept_read) begin
            // All beats are still to come, the first read is next cycle
            state      <= emif_model_pkg::st_read_burst;
            beats_left <= burstcount;
            burst_addr <= address[emif_model_pkg::mem_addr_w-1:0];
          end else if (accept_write) begin
            // One beat is already done, so only longer bursts leave idle
            beats_left <= burstcount - 1'b1;
            burst_addr <= address[emif_model_pkg::mem_addr_w-1:0] + 1'b1;
            if (burstcount > emif_model_pkg::last_beat) begin
              state <= emif_model_pkg::st_write_burst;
            end
          end
        end

        emif_model_pkg::st_read_burst: begin
          // Storage answers in the same cycle and the word is registered here
          readdata      <= store_rd_data;
          readdatavalid <= 1'b1;
          burst_addr    <= burst_addr + 1'b1;
          beats_left    <= beats_left - 1'b1;
          if (beats_left == emif_model_pkg::last_beat) begin
            state <= emif_model_pkg::st_idle;
          end
        end

        emif_model_pkg::st_write_burst: begin
          // A low write strobe stalls the burst without losing its place
          if (write) begin
            burst_addr <= burst_addr + 1'b1;
            beats_left <= beats_left - 1'b1;
            if (beats_left == emif_model_pkg::last_beat) begin
              state <= emif_model_pkg::st_idle;
            end
          end
        end

        default: begin
          state <= emif_model_pkg::st_idle;
        end
      endcase
    end
  end

  // Byte enables are payload and are only loaded when a write is accepted
  always_ff @(posedge DDR4_USERCLK) begin
    if (accept_write) begin
      burst_byteenable <= byteenable;
    end
  end

  // ============================================================
  // Storage
  // ============================================================

  emif_bank_store u_store (
    .DDR4_USERCLK  (DDR4_USERCLK),
    .reset         (reset),
    .wr_en         (store_wr_en),
    .wr_addr       (store_wr_addr),
    .wr_data       (writedata),
    .wr_byteenable (store_wr_byteenable),
    .rd_addr       (burst_addr),
    .rd_data       (store_rd_data)
  );

endmodule

/* emif_bank_store.sv */
/*
 Word storage for one bank with a written-flag per word.
 Reads are combinational and return zero for never-written words.
 Reset clears only the flags, which is enough to make every word read as zero.
*/

`timescale 1ns/10ps

module emif_bank_store (
  input  logic                                  DDR4_USERCLK,
  input  logic                                  reset,
  // Write port, one word per cycle
  input  logic                                  wr_en,
  input  logic [emif_model_pkg::mem_addr_w-1:0] wr_addr,
  input  logic [emif_model_pkg::data_w-1:0]     wr_data,
  input  logic [emif_model_pkg::data_bytes-1:0] wr_byteenable,
  // Read port, data comes back in the same cycle
  input  logic [emif_model_pkg::mem_addr_w-1:0] rd_addr,
  output logic [emif_model_pkg::data_w-1:0]     rd_data
);

  // ============================================================
  // Storage and flags
  // ============================================================

  // Word array, contents are only meaningful where the flag is set
  logic [emif_model_pkg::data_w-1:0] mem [0:emif_model_pkg::mem_depth-1];

  // One bit per word that records whether the word was ever written
  logic [emif_model_pkg::mem_depth-1:0] written;

  // Byte enables widened to one bit per data bit
  logic [emif_model_pkg::data_w-1:0] bit_mask;

  // Current contents of the target word, zero if never written
  logic [emif_model_pkg::data_w-1:0] old_word;

  // Word after the new bytes are merged in
  logic [emif_model_pkg::data_w-1:0] merged_word;

  // ============================================================
  // Byte-masked merge
  // ============================================================

  // Each byteenable bit covers a full byte lane
  always_comb begin
    for (int i = 0; i < emif_model_pkg::data_bytes; i++) begin
      bit_mask[i*emif_model_pkg::byte_w +: emif_model_pkg::byte_w] =
        {emif_model_pkg::byte_w{wr_byteenable[i]}};
    end
  end

  // A word that was never written counts as all zeros before the merge
  assign old_word = written[wr_addr] ? mem[wr_addr] : '0;

  // New bytes where enabled, old bytes everywhere else
  assign merged_word = (old_word & ~bit_mask) | (wr_data & bit_mask);

  // Flags are control state and are cleared by reset
  always_ff @(posedge DDR4_USERCLK) begin
    if (reset) begin
      written <= '0;
    end else if (wr_en) begin
      written[wr_addr] <= 1'b1;
    end
  end

  // The word array itself has no reset
  // A write that lands during reset is hidden because its flag stays clear
  always_ff @(posedge DDR4_USERCLK) begin
    if (wr_en) begin
      mem[wr_addr] <= merged_word;
    end
  end

  // ============================================================
  // Read port
  // ============================================================

  // Unwritten words read as zero, matching an empty memory
  assign rd_data = written[rd_addr] ? mem[rd_addr] : '0;

endmodule

/* emif_dual_bank_model.f */
emif_model_pkg.sv
emif_bank_store.sv
emif_bank.sv
emif_dual_bank_model.sv
emif_dual_bank_model_sva.sv
emif_dual_bank_model_tb.sv

/* emif_dual_bank_model.sv */
/*
 Two independent external-memory banks, a and b, on one clock and one reset.
 Each bank holds 256 words and aliases higher addresses onto them.
*/

`timescale 1ns/10ps

module emif_dual_bank_model (
  input  logic                                  DDR4_USERCLK,
  input  logic                                  reset,

  // ============================================================
  // Bank a
  // ============================================================
  input  logic                                  ddr4a_read,
  input  logic                                  ddr4a_write,
  input  logic [emif_model_pkg::addr_w-1:0]     ddr4a_address,
  input  logic [emif_model_pkg::burst_w-1:0]    ddr4a_burstcount,
  input  logic [emif_model_pkg::data_w-1:0]     ddr4a_writedata,
  input  logic [emif_model_pkg::data_bytes-1:0] ddr4a_byteenable,
  output logic                                  ddr4a_waitrequest,
  output logic [emif_model_pkg::data_w-1:0]     ddr4a_readdata,
  output logic                                  ddr4a_readdatavalid,

  // ============================================================
  // Bank b
  // ============================================================
  input  logic                                  ddr4b_read,
  input  logic                                  ddr4b_write,
  input  logic [emif_model_pkg::addr_w-1:0]     ddr4b_address,
  input  logic [emif_model_pkg::burst_w-1:0]    ddr4b_burstcount,
  input  logic [emif_model_pkg::data_w-1:0]     ddr4b_writedata,
  input  logic [emif_model_pkg::data_bytes-1:0] ddr4b_byteenable,
  output logic                                  ddr4b_waitrequest,
  output logic [emif_model_pkg::data_w-1:0]     ddr4b_readdata,
  output logic                                  ddr4b_readdatavalid
);

  // The banks share nothing but the clock and reset
  // Bursts on a and b run at the same time without interaction

  emif_bank u_bank_a (
    .DDR4_USERCLK  (DDR4_USERCLK),
    .reset         (reset),
    .read          (ddr4a_read),
    .write         (ddr4a_write),
    .address       (ddr4a_address),
    .burstcount    (ddr4a_burstcount),
    .writedata     (ddr4a_writedata),
    .byteenable    (ddr4a_byteenable),
    .waitrequest   (ddr4a_waitrequest),
    .readdatavalid (ddr4a_readdatavalid),
    .readdata      (ddr4a_readdata)
  );

  // Same controller for bank b
  emif_bank u_bank_b (
    .DDR4_USERCLK  (DDR4_USERCLK),
    .reset         (reset),
    .read          (ddr4b_read),
    .write         (ddr4b_write),
    .address       (ddr4b_address),
    .burstcount    (ddr4b_burstcount),
    .writedata     (ddr4b_writedata),
    .byteenable    (ddr4b_byteenable),
    .waitrequest   (ddr4b_waitrequest),
    .readdatavalid (ddr4b_readdatavalid),
    .readdata      (ddr4b_readdata)
  );

endmodule

/* emif_dual_bank_model_sva.sv */
/*
 Protocol assertions for one memory bank, bound into every emif_bank instance.
 All rules are sampled on the rising edge of DDR4_USERCLK.
*/

`timescale 1ns/10ps

module emif_bank_sva (
  input logic DDR4_USERCLK,
  input logic reset,
  input logic write,
  input logic waitrequest,
  input logic readdatavalid
);

  // ============================================================
  // Read and write rules
  // ============================================================

  // Every returned word follows a cycle in which the read burst was running
  a_valid_after_wait: assert property (
    @(posedge DDR4_USERCLK) disable iff (reset)
      readdatavalid |-> $past(waitrequest)
  ) else $error("readdatavalid without waitrequest in the previous cycle");

  // Writes never see the host held off
  a_no_wait_on_write: assert property (
    @(posedge DDR4_USERCLK) disable iff (reset)
      !(waitrequest && write)
  ) else $error("waitrequest high in a cycle with write high");

  // ============================================================
  // Reset rule
  // ============================================================

  // The cycle after a reset edge shows both response strobes low
  a_quiet_after_reset: assert property (
    @(posedge DDR4_USERCLK)
      $past(reset) |-> (!waitrequest && !readdatavalid)
  ) else $error("waitrequest or readdatavalid high right after reset");

endmodule

bind emif_bank emif_bank_sva u_sva (
  .DDR4_USERCLK  (DDR4_USERCLK),
  .reset         (reset),
  .write         (write),
  .waitrequest   (waitrequest),
  .readdatavalid (readdatavalid)
);

/* emif_dual_bank_model_tb.sv */
/*
 Table-driven testbench for the two-bank memory model.
 A shadow memory applies the byte-merge rule and supplies every expected read word.
 Steps run one after another, so the two banks are never busy at the same time.
*/

`timescale 1ns/10ps

module emif_dual_bank_model_tb;

  // ============================================================
  // Step table types and testbench state
  // ============================================================

  typedef enum {op_write, op_read, op_reset} step_op_t;

  // One row of the table, the count field is the reset length for op_reset
  typedef struct {
    string                                 name;
    step_op_t                              op;
    int                                    bank;
    logic [emif_model_pkg::addr_w-1:0]     addr;
    logic [emif_model_pkg::burst_w-1:0]    count;
    logic [emif_model_pkg::data_bytes-1:0] be;
  } step_t;

  logic DDR4_USERCLK = 1'b0;
  logic reset;

  // Host side, index 0 is bank a and index 1 is bank b
  logic [1:0]                            host_read;
  logic [1:0]                            host_write;
  logic [emif_model_pkg::addr_w-1:0]     host_address    [0:1];
  logic [emif_model_pkg::burst_w-1:0]    host_burstcount [0:1];
  logic [emif_model_pkg::data_w-1:0]     host_writedata  [0:1];
  logic [emif_model_pkg::data_bytes-1:0] host_byteenable [0:1];

  // Model side
  logic [1:0]                        bank_waitrequest;
  logic [1:0]                        bank_readdatavalid;
  logic [emif_model_pkg::data_w-1:0] bank_readdata [0:1];

  // Expected contents of both banks, zero where nothing was written
  logic [emif_model_pkg::data_w-1:0] shadow [0:1][0:emif_model_pkg::mem_depth-1];

  step_t  steps [$];
  integer seed = 32'hdb39e803;
  int     errors = 0;
  int     checks = 0;
  int     limit_cycles = 0;

  always #5 DDR4_USERCLK = ~DDR4_USERCLK;

  emif_dual_bank_model u_dut (
    .DDR4_USERCLK        (DDR4_USERCLK),
    .reset               (reset),
    .ddr4a_read          (host_read[0]),
    .ddr4a_write         (host_write[0]),
    .ddr4a_address       (host_address[0]),
    .ddr4a_burstcount    (host_burstcount[0]),
    .ddr4a_writedata     (host_writedata[0]),
    .ddr4a_byteenable    (host_byteenable[0]),
    .ddr4a_waitrequest   (bank_waitrequest[0]),
    .ddr4a_readdata      (bank_readdata[0]),
    .ddr4a_readdatavalid (bank_readdatavalid[0]),
    .ddr4b_read          (host_read[1]),
    .ddr4b_write         (host_write[1]),
    .ddr4b_address       (host_address[1]),
    .ddr4b_burstcount    (host_burstcount[1]),
    .ddr4b_writedata     (host_writedata[1]),
    .ddr4b_byteenable    (host_byteenable[1]),
    .ddr4b_waitrequest   (bank_waitrequest[1]),
    .ddr4b_readdata      (bank_readdata[1]),
    .ddr4b_readdatavalid (bank_readdatavalid[1])
  );

  // ============================================================
  // Shadow memory and stimulus helpers
  // ============================================================

  // Wide random word built 32 bits at a time from the seeded generator
  function automatic logic [emif_model_pkg::data_w-1:0] random_word();
    logic [emif_model_pkg::data_w-1:0] w;
    for (int i = 0; i < emif_model_pkg::data_w / 32; i++) begin
      w[i*32 +: 32] = $random(seed);
    end
    return w;
  endfunction

  // Enabled bytes take the new data, every other byte keeps its old value
  function automatic void shadow_write(input int bank,
                                       input logic [emif_model_pkg::mem_addr_w-1:0] addr,
                                       input logic [emif_model_pkg::data_w-1:0] data,
                                       input logic [emif_model_pkg::data_bytes-1:0] be);
    for (int b = 0; b < emif_model_pkg::data_bytes; b++) begin
      if (be[b]) begin
        shadow[bank][addr][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endfunction

  // An empty bank reads as zero everywhere
  function automatic void shadow_clear();
    for (int k = 0; k < 2; k++) begin
      for (int w = 0; w < emif_model_pkg::mem_depth; w++) begin
        shadow[k][w] = '0;
      end
    end
  endfunction

  function automatic void add_step(input string name, input step_op_t op, input int bank,
                                   input int addr, input int count,
                                   input logic [emif_model_pkg::data_bytes-1:0] be);
    step_t s;
    s.name  = name;
    s.op    = op;
    s.bank  = bank;
    s.addr  = addr[emif_model_pkg::addr_w-1:0];
    s.count = count[emif_model_pkg::burst_w-1:0];
    s.be    = be;
    steps.push_back(s);
  endfunction

  function automatic void build_table();
    logic [emif_model_pkg::data_bytes-1:0] full_be;
    full_be = '1;
    add_step("rd_blank_a",         op_read,  0, 10,         3,  full_be);
    add_step("rd_blank_b",         op_read,  1, 200,        2,  full_be);
    add_step("wr_burst_a",         op_write, 0, 16,         4,  full_be);
    add_step("rd_burst_a",         op_read,  0, 16,         4,  full_be);
    // Partial lanes over the second word of the earlier burst
    add_step("wr_partial_a",       op_write, 0, 17,         1,  64'h0f0f_0000_ffff_00a5);
    add_step("rd_merge_a",         op_read,  0, 16,         4,  full_be);
    add_step("wr_partial_burst_a", op_write, 0, 18,         3,  64'hff00_ff00_0000_ffff);
    add_step("rd_partial_burst_a", op_read,  0, 18,         3,  full_be);
    // Bank b must not see anything that went to bank a
    add_step("rd_isolation_b",     op_read,  1, 16,         4,  full_be);
    add_step("wr_burst_b",         op_write, 1, 16,         2,  full_be);
    add_step("rd_unchanged_a",     op_read,  0, 16,         4,  full_be);
    add_step("rd_burst_b",         op_read,  1, 16,         2,  full_be);
    add_step("rd_long_a",          op_read,  0, 0,          32, full_be);
    // High address bits are ignored, so this lands on word 0x28
    add_step("wr_alias_a",         op_write, 0, 'h3ffff28,  2,  full_be);
    add_step("rd_alias_a",         op_read,  0, 'h28,       2,  full_be);
    add_step("wr_wrap_b",          op_write, 1, 254,        4,  full_be);
    add_step("rd_wrap_b",          op_read,  1, 254,        4,  full_be);
    // Both banks last returned written words, so readdata is nonzero here
    add_step("reset_mid",          op_reset, 0, 0,          3,  full_be);
    add_step("rd_after_reset_a",   op_read,  0, 16,         4,  full_be);
    add_step("rd_after_reset_b",   op_read,  1, 254,        4,  full_be);
  endfunction

  // ============================================================
  // Bus tasks
  // ============================================================

  // Drives one write burst, with a one-cycle gap before the third beat
  task automatic run_write(input step_t s);
    logic [emif_model_pkg::mem_addr_w-1:0] a;
    logic [emif_model_pkg::data_w-1:0]     data;
    a = s.addr[emif_model_pkg::mem_addr_w-1:0];
    for (int beat = 0; beat < int'(s.count); beat++) begin
      if (beat == 2) begin
        @(posedge DDR4_USERCLK);
        host_write[s.bank] <= 1'b0;
      end
      data = random_word();
      @(posedge DDR4_USERCLK);
      host_write[s.bank]      <= 1'b1;
      host_address[s.bank]    <= s.addr;
      host_burstcount[s.bank] <= s.count;
      host_writedata[s.bank]  <= data;
      // Only the first beat's lanes count, later beats carry the inverse
      host_byteenable[s.bank] <= (beat == 0) ? s.be : ~s.be;
      shadow_write(s.bank, a, data, s.be);
      a = a + 1'b1;
    end
    @(posedge DDR4_USERCLK);
    host_write[s.bank] <= 1'b0;
  endtask

  // Issues one read burst, checks each word and the waitrequest length
  task automatic run_read(input step_t s);
    logic [emif_model_pkg::mem_addr_w-1:0] a;
    logic [emif_model_pkg::data_w-1:0]     expected;
    int got;
    int wait_cycles;
    a = s.addr[emif_model_pkg::mem_addr_w-1:0];
    got = 0;
    wait_cycles = 0;
    @(negedge DDR4_USERCLK);
    while (bank_waitrequest[s.bank]) begin
      @(negedge DDR4_USERCLK);
    end
    @(posedge DDR4_USERCLK);
    host_read[s.bank]       <= 1'b1;
    host_address[s.bank]    <= s.addr;
    host_burstcount[s.bank] <= s.count;
    @(posedge DDR4_USERCLK);
    host_read[s.bank] <= 1'b0;
    // Outputs are sampled on the falling edge, half a cycle after they change
    while (got < int'(s.count)) begin
      @(negedge DDR4_USERCLK);
      if (bank_waitrequest[s.bank]) begin
        wait_cycles++;
      end
      if (bank_readdatavalid[s.bank]) begin
        expected = shadow[s.bank][a];
        checks++;
        if (bank_readdata[s.bank] !== expected) begin
          errors++;
          $display("ERROR %s: word %0d expected %h actual %h",
                   s.name, got, expected, bank_readdata[s.bank]);
        end
        a = a + 1'b1;
        got++;
      end
    end
    checks++;
    if (wait_cycles != int'(s.count)) begin
      errors++;
      $display("ERROR %s: waitrequest cycles expected %0d actual %0d",
               s.name, s.count, wait_cycles);
    end
  endtask

  task automatic run_reset(input int cycles);
    @(posedge DDR4_USERCLK);
    reset <= 1'b1;
    repeat (cycles) @(posedge DDR4_USERCLK);
    reset <= 1'b0;
    shadow_clear();
  endtask

  // Both banks must come out of reset quiet with readdata cleared
  task automatic check_reset_outputs(input string name);
    @(negedge DDR4_USERCLK);
    for (int b = 0; b < 2; b++) begin
      checks++;
      if (bank_waitrequest[b] !== 1'b0 || bank_readdatavalid[b] !== 1'b0) begin
        errors++;
        $display("ERROR %s: bank %0d waitrequest,readdatavalid expected 00 actual %b%b",
                 name, b, bank_waitrequest[b], bank_readdatavalid[b]);
      end
      checks++;
      if (bank_readdata[b] !== '0) begin
        errors++;
        $display("ERROR %s: bank %0d readdata expected %h actual %h",
                 name, b, {emif_model_pkg::data_w{1'b0}}, bank_readdata[b]);
      end
    end
  endtask

  // ============================================================
  // Main sequence and watchdog
  // ============================================================

  initial begin : main_sequence
    int total;
    total = 0;
    reset      <= 1'b1;
    host_read  <= '0;
    host_write <= '0;
    for (int b = 0; b < 2; b++) begin
      host_address[b]    <= '0;
      host_burstcount[b] <= '0;
      host_writedata[b]  <= '0;
      host_byteenable[b] <= '0;
    end
    build_table();
    shadow_clear();
    foreach (steps[i]) begin
      total += int'(steps[i].count);
    end
    limit_cycles = total * 4 + 200;
    repeat (5) @(posedge DDR4_USERCLK);
    reset <= 1'b0;
    check_reset_outputs("initial_reset");
    foreach (steps[i]) begin
      case (steps[i].op)
        op_write: run_write(steps[i]);
        op_read:  run_read(steps[i]);
        default: begin
          run_reset(int'(steps[i].count));
          check_reset_outputs(steps[i].name);
        end
      endcase
    end
    $display("Closing: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // The limit scales with the total burst length of the table
  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge DDR4_USERCLK);
    $display("Timeout: the run was still busy after %0d cycles", limit_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* emif_model_pkg.sv */
/*
 Shared widths and the burst controller state for the two-bank memory model.
 Only mem_addr_w address bits are decoded, so higher word addresses alias.
*/

package emif_model_pkg;

  // ============================================================
  // Bus widths
  // ============================================================

  // One byte lane is eight bits wide
  localparam int byte_w = 8;

  // Byte lanes in one data word, one byteenable bit per lane
  localparam int data_bytes = 64;

  // Full data word width of the memory bus
  localparam int data_w = byte_w * data_bytes;

  // Word address width on the host side
  // The low byte-address bits are not part of this port
  localparam int addr_w = 26;

  // Width of the burstcount port, which allows bursts of up to 127 words
  localparam int burst_w = 7;

  // ============================================================
  // Storage geometry
  // ============================================================

  // Address bits that the storage actually decodes
  localparam int mem_addr_w = 8;

  // Words held per bank
  localparam int mem_depth = 1 << mem_addr_w;

  // Beat count at which a burst ends on the current beat
  localparam logic [burst_w-1:0] last_beat = 1;

  // ============================================================
  // Burst controller state
  // ============================================================

  // Idle accepts commands, the two burst states each run one burst
  typedef enum logic [1:0] {
    st_idle,
    st_read_burst,
    st_write_burst
  } bank_state_t;

endpackage
